// File: include/bf16_params.svh
// ----------------------------------------------------------------------
// BF16 reduction parameters
// ----------------------------------------------------------------------

`ifndef BF16_PARAMS_SVH
`define BF16_PARAMS_SVH

// Lanes carried by one command
`define BF16_NUM_LANES 8

// Width of the winning lane index, log2 of the lane count
`define BF16_IDX_W 3

// Width of the command tag returned with the result
`define BF16_TAG_W 4

// Width of one BF16 word
`define BF16_W 16

// Raw opcode width on the command port
`define BF16_OP_W 2

`endif

// File: design/bf16_pkg.sv
// ----------------------------------------------------------------------
// BF16 reduction types and interfaces
// ----------------------------------------------------------------------
`default_nettype none

`include "bf16_params.svh"

package bf16_pkg;

    // Reduction opcodes, code 3 is reserved and flagged as an error
    typedef enum logic [`BF16_OP_W-1:0] {
        OP_MAXABS    = 2'd0,
        OP_SCALE_EXP = 2'd1,
        OP_ZERO_TEST = 2'd2,
        OP_ILLEGAL   = 2'd3
    } bf16_op_e;

    // Raw BF16 word
    typedef logic [`BF16_W-1:0] bf16_t;

    // Field view of a BF16 word
    typedef struct packed {
        logic       sign;
        logic [7:0] exp;
        logic [6:0] mant;
    } bf16_fields_t;

    // All lanes of one command, lane 0 in the low bits
    typedef bf16_t [`BF16_NUM_LANES-1:0] bf16_lanes_t;

endpackage : bf16_pkg

// Decoded command, decode to execute
interface reduce_cmd_if import bf16_pkg::*; ();
    logic                   valid;
    bf16_op_e               op;
    logic                   illegal;
    logic [`BF16_TAG_W-1:0] tag;
    bf16_lanes_t            lanes;

    modport src (output valid, op, illegal, tag, lanes);
    modport dst (input  valid, op, illegal, tag, lanes);
endinterface : reduce_cmd_if

// Reduction result, execute to result format
interface reduce_res_if import bf16_pkg::*; ();
    logic                   valid;
    bf16_op_e               op;
    logic                   illegal;
    logic [`BF16_TAG_W-1:0] tag;
    bf16_t                  max_value;
    logic [`BF16_IDX_W-1:0] max_index;
    logic                   all_zero;

    modport src (output valid, op, illegal, tag, max_value, max_index, all_zero);
    modport dst (input  valid, op, illegal, tag, max_value, max_index, all_zero);
endinterface : reduce_res_if

`default_nettype wire

// File: design/bf16_comparator.sv
// ----------------------------------------------------------------------
// BF16 magnitude comparator
// ----------------------------------------------------------------------
`default_nettype none

module bf16_comparator
    import bf16_pkg::*;
(
    input  bf16_t i_a,
    input  bf16_t i_b,
    output bf16_t o_max,
    output logic  o_a_wins
);

    bf16_fields_t a_f;
    bf16_fields_t b_f;
    logic [14:0]  mag_a;
    logic [14:0]  mag_b;

    assign a_f = i_a;
    assign b_f = i_b;

    // Magnitude is exponent and mantissa, sign dropped
    assign mag_a = {a_f.exp, a_f.mant};
    assign mag_b = {b_f.exp, b_f.mant};

    // Unsigned compare on the magnitude bits
    // NaN has all-ones exponent and nonzero mantissa so it sits above infinity
    // Equal magnitudes go to a, the lower-index side of the pair
    assign o_a_wins = (mag_a >= mag_b);

    // Winner keeps its own sign
    assign o_max = o_a_wins ? i_a : i_b;

endmodule : bf16_comparator

`default_nettype wire

// File: design/bf16_max_tree.sv
// ----------------------------------------------------------------------
// BF16 max-magnitude tree
// ----------------------------------------------------------------------
`default_nettype none

`include "bf16_params.svh"

module bf16_max_tree
    import bf16_pkg::*;
#(
    parameter int NUM_INPUTS = `BF16_NUM_LANES
) (
    input  logic [NUM_INPUTS*`BF16_W-1:0]  i_values,
    output bf16_t                          o_max,
    output logic [$clog2(NUM_INPUTS)-1:0]  o_max_index,
    output logic                           o_all_zero
);

    localparam int LEVELS    = $clog2(NUM_INPUTS);
    localparam int IDX_W     = $clog2(NUM_INPUTS);
    localparam int NUM_NODES = 2 * NUM_INPUTS - 1;

    // Flat node store
    // Leaves occupy 0 .. NUM_INPUTS-1, each level follows the previous one
    bf16_t            node_val [NUM_NODES];
    logic [IDX_W-1:0] node_idx [NUM_NODES];
    logic [NUM_INPUTS-1:0] lane_zero;

    // ------------------------------------------------------------------
    // Leaves and zero detect
    // ------------------------------------------------------------------
    for (genvar i = 0; i < NUM_INPUTS; i++) begin : gen_leaf
        bf16_fields_t lane_f;

        assign node_val[i] = i_values[i*`BF16_W +: `BF16_W];
        assign node_idx[i] = IDX_W'(i);
        assign lane_f      = node_val[i];
        // Zero exponent covers true zero and subnormals
        assign lane_zero[i] = (lane_f.exp == 8'h00);
    end

    assign o_all_zero = &lane_zero;

    // ------------------------------------------------------------------
    // Comparator levels
    // ------------------------------------------------------------------
    for (genvar l = 1; l <= LEVELS; l++) begin : gen_level
        // Level l starts at 2N - 2N/2^l and holds N/2^l nodes
        localparam int SRC_BASE = 2 * NUM_INPUTS - ((2 * NUM_INPUTS) >> (l - 1));
        localparam int DST_BASE = 2 * NUM_INPUTS - ((2 * NUM_INPUTS) >> l);
        localparam int COUNT    = NUM_INPUTS >> l;

        for (genvar n = 0; n < COUNT; n++) begin : gen_node
            logic a_wins;

            // Adjacent pairs keep the lower index on the a side
            bf16_comparator u_cmp (
                .i_a      (node_val[SRC_BASE + 2*n]),
                .i_b      (node_val[SRC_BASE + 2*n + 1]),
                .o_max    (node_val[DST_BASE + n]),
                .o_a_wins (a_wins)
            );

            // Winning index rides along with the value
            assign node_idx[DST_BASE + n] = a_wins ? node_idx[SRC_BASE + 2*n]
                                                   : node_idx[SRC_BASE + 2*n + 1];
        end
    end

    // Root is the last node
    assign o_max       = node_val[NUM_NODES-1];
    assign o_max_index = node_idx[NUM_NODES-1];

endmodule : bf16_max_tree

`default_nettype wire

// File: design/bf16_op_decode.sv
// ----------------------------------------------------------------------
// Command decode stage
// ----------------------------------------------------------------------
`default_nettype none

`include "bf16_params.svh"

module bf16_op_decode
    import bf16_pkg::*;
(
    input  wire logic                   i_clk,
    input  wire logic                   i_rst,
    input  wire logic                   i_valid,
    input  wire logic [`BF16_OP_W-1:0]  i_op,
    input  wire logic [`BF16_TAG_W-1:0] i_tag,
    input  bf16_lanes_t                 i_lanes,
    reduce_cmd_if.src                   cmd
);

    bf16_op_e op_dec;
    logic     op_illegal;

    // Raw code to enum, reserved code marks the item illegal
    assign op_dec     = bf16_op_e'(i_op);
    assign op_illegal = (op_dec == OP_ILLEGAL);

    // Valid strobe, one cycle per accepted command
    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            cmd.valid <= 1'b0;
        end else begin
            cmd.valid <= i_valid;
        end
    end

    // Payload only loads on a strobe
    always_ff @(posedge i_clk) begin
        if (i_valid) begin
            cmd.op      <= op_dec;
            cmd.illegal <= op_illegal;
            cmd.tag     <= i_tag;
            cmd.lanes   <= i_lanes;
        end
    end

endmodule : bf16_op_decode

`default_nettype wire

// File: design/bf16_reduce_exec.sv
// ----------------------------------------------------------------------
// Reduction execute stage
// ----------------------------------------------------------------------
`default_nettype none

`include "bf16_params.svh"

module bf16_reduce_exec
    import bf16_pkg::*;
(
    input  wire logic i_clk,
    input  wire logic i_rst,
    reduce_cmd_if.dst cmd,
    reduce_res_if.src res
);

    bf16_t                  tree_max;
    logic [`BF16_IDX_W-1:0] tree_index;
    logic                   tree_all_zero;

    // Tree runs on every item, the result stage picks what it needs
    bf16_max_tree #(
        .NUM_INPUTS (`BF16_NUM_LANES)
    ) u_max_tree (
        .i_values    (cmd.lanes),
        .o_max       (tree_max),
        .o_max_index (tree_index),
        .o_all_zero  (tree_all_zero)
    );

    // ------------------------------------------------------------------
    // Stage register
    // ------------------------------------------------------------------
    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            res.valid <= 1'b0;
        end else begin
            res.valid <= cmd.valid;
        end
    end

    // Tree outputs travel next to the command fields
    always_ff @(posedge i_clk) begin
        if (cmd.valid) begin
            res.op        <= cmd.op;
            res.illegal   <= cmd.illegal;
            res.tag       <= cmd.tag;
            res.max_value <= tree_max;
            res.max_index <= tree_index;
            res.all_zero  <= tree_all_zero;
        end
    end

endmodule : bf16_reduce_exec

`default_nettype wire

// File: design/bf16_result_format.sv
// ----------------------------------------------------------------------
// Result format stage
// ----------------------------------------------------------------------
`default_nettype none

`include "bf16_params.svh"

module bf16_result_format
    import bf16_pkg::*;
(
    input  wire logic                    i_clk,
    input  wire logic                    i_rst,
    reduce_res_if.dst                    res,
    output logic                         o_valid,
    output logic [`BF16_TAG_W-1:0]       o_tag,
    output logic [`BF16_W-1:0]           o_result,
    output logic [`BF16_IDX_W-1:0]       o_index,
    output logic                         o_error
);

    bf16_fields_t           max_f;
    logic [`BF16_W-1:0]     word;
    logic [`BF16_IDX_W-1:0] index;

    assign max_f = res.max_value;

    // ------------------------------------------------------------------
    // Output word select
    // ------------------------------------------------------------------
    always_comb begin
        case (res.op)
            OP_MAXABS:    word = res.max_value;
            // Biased exponent in the low byte, usable as a block scale
            OP_SCALE_EXP: word = {8'h00, max_f.exp};
            OP_ZERO_TEST: word = {15'd0, res.all_zero};
            default:      word = '0;
        endcase
        // Illegal item returns zero word and zero index
        if (res.illegal) begin
            word  = '0;
            index = '0;
        end else begin
            index = res.max_index;
        end
    end

    // Control flags
    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            o_valid <= 1'b0;
            o_error <= 1'b0;
        end else begin
            o_valid <= res.valid;
            o_error <= res.valid & res.illegal;
        end
    end

    // Output data
    always_ff @(posedge i_clk) begin
        if (res.valid) begin
            o_tag    <= res.tag;
            o_result <= word;
            o_index  <= index;
        end
    end

endmodule : bf16_result_format

`default_nettype wire

// File: design/bf16_reduce_top.sv
// ----------------------------------------------------------------------
// BF16 block reduction unit
// ----------------------------------------------------------------------
`default_nettype none

`include "bf16_params.svh"

module bf16_reduce_top (
    input  wire logic                                i_clk,
    input  wire logic                                i_rst,
    input  wire logic                                i_valid,
    input  wire logic [`BF16_OP_W-1:0]               i_op,
    input  wire logic [`BF16_TAG_W-1:0]              i_tag,
    input  wire logic [`BF16_NUM_LANES*`BF16_W-1:0]  i_values_flat,
    output logic                                     o_valid,
    output logic [`BF16_TAG_W-1:0]                   o_tag,
    output logic [`BF16_W-1:0]                       o_result,
    output logic [`BF16_IDX_W-1:0]                   o_index,
    output logic                                     o_error
);

    // Stage links
    reduce_cmd_if u_cmd_if ();
    reduce_res_if u_res_if ();

    // Stage 1, command register and opcode decode
    bf16_op_decode u_op_decode (
        .i_clk   (i_clk),
        .i_rst   (i_rst),
        .i_valid (i_valid),
        .i_op    (i_op),
        .i_tag   (i_tag),
        .i_lanes (i_values_flat),
        .cmd     (u_cmd_if.src)
    );

    // Stage 2, max tree
    bf16_reduce_exec u_reduce_exec (
        .i_clk (i_clk),
        .i_rst (i_rst),
        .cmd   (u_cmd_if.dst),
        .res   (u_res_if.src)
    );

    // Stage 3, output packing
    bf16_result_format u_result_format (
        .i_clk    (i_clk),
        .i_rst    (i_rst),
        .res      (u_res_if.dst),
        .o_valid  (o_valid),
        .o_tag    (o_tag),
        .o_result (o_result),
        .o_index  (o_index),
        .o_error  (o_error)
    );

endmodule : bf16_reduce_top

`default_nettype wire

// File: verification/bf16_reduce_checker.sv
// ----------------------------------------------------------------------
// BF16 reduction output checker
// ----------------------------------------------------------------------
`default_nettype none

`include "bf16_params.svh"

module bf16_reduce_checker (
    input  wire logic                   i_clk,
    input  wire logic                   i_rst,
    input  wire logic                   i_in_valid,
    input  wire logic                   i_out_valid,
    input  wire logic [`BF16_TAG_W-1:0] i_out_tag,
    input  wire logic [`BF16_W-1:0]     i_out_result,
    input  wire logic [`BF16_IDX_W-1:0] i_out_index,
    input  wire logic                   i_out_error,
    input  wire logic                   i_end,
    output int                          o_value_errors,
    output int                          o_order_errors,
    output int                          o_checked
);

    // Expected values, one entry per command line
    logic [`BF16_TAG_W-1:0] exp_tag_q [$];
    logic [`BF16_W-1:0]     exp_res_q [$];
    logic [`BF16_IDX_W-1:0] exp_idx_q [$];
    logic                   exp_err_q [$];
    // Cycle numbers of the input strobes still in flight
    int                     drive_q [$];

    int cycle        = 0;
    int value_errors = 0;
    int order_errors = 0;
    int file_errors  = 0;
    int checked      = 0;
    bit end_seen     = 1'b0;

    assign o_value_errors = value_errors;
    assign o_order_errors = order_errors + file_errors;
    assign o_checked      = checked;

    // ------------------------------------------------------------------
    // Expected values from the command file
    // ------------------------------------------------------------------
    initial begin
        int                     fd;
        int                     n;
        string                  line;
        logic [1:0]             op;
        logic [`BF16_TAG_W-1:0] tag;
        logic [`BF16_W-1:0]     lane [`BF16_NUM_LANES];
        logic [`BF16_W-1:0]     res;
        logic [`BF16_IDX_W-1:0] idx;
        logic                   err;
        fd = $fopen("verification/bf16_reduce_input.txt", "r");
        if (fd == 0) begin
            $display("Checker could not open the command file");
            file_errors++;
        end else begin
            while ($fgets(line, fd) > 0) begin
                // Blank lines and column notes
                if (line.len() < 2 || line.getc(0) == "#") begin
                    continue;
                end
                n = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h", op, tag,
                            lane[0], lane[1], lane[2], lane[3], lane[4], lane[5],
                            lane[6], lane[7], res, idx, err);
                if (n != 13) begin
                    $display("Command file line has %0d fields instead of 13", n);
                    file_errors++;
                end else begin
                    exp_tag_q.push_back(tag);
                    exp_res_q.push_back(res);
                    exp_idx_q.push_back(idx);
                    exp_err_q.push_back(err);
                end
            end
            $fclose(fd);
        end
    end

    // One field against its expected value
    task compare_field(input string name, input logic [15:0] expected,
                       input logic [15:0] actual);
        if (actual !== expected) begin
            $display("Error: %s expected %h got %h", name, expected, actual);
            value_errors++;
        end
    endtask

    // Output strobe against the next expected line
    task check_output();
        int                     latency;
        logic [`BF16_TAG_W-1:0] e_tag;
        logic [`BF16_W-1:0]     e_res;
        logic [`BF16_IDX_W-1:0] e_idx;
        logic                   e_err;
        if (exp_tag_q.size() == 0) begin
            $display("Output strobe with tag %h came after the last command line", i_out_tag);
            order_errors++;
        end else begin
            e_tag = exp_tag_q.pop_front();
            e_res = exp_res_q.pop_front();
            e_idx = exp_idx_q.pop_front();
            e_err = exp_err_q.pop_front();
            compare_field("o_tag", 16'(e_tag), 16'(i_out_tag));
            compare_field("o_result", e_res, i_out_result);
            compare_field("o_index", 16'(e_idx), 16'(i_out_index));
            compare_field("o_error", 16'(e_err), 16'(i_out_error));
            checked++;
        end
        // Pipeline depth is fixed at three stages
        if (drive_q.size() == 0) begin
            $display("Output strobe with tag %h has no matching input strobe", i_out_tag);
            order_errors++;
        end else begin
            latency = cycle - drive_q.pop_front();
            if (latency != 3) begin
                $display("Output with tag %h came %0d cycles after its input, not 3",
                         i_out_tag, latency);
                order_errors++;
            end
        end
    endtask

    // ------------------------------------------------------------------
    // Sampling on the rising edge, after the DUT settled
    // ------------------------------------------------------------------
    always @(posedge i_clk) begin
        cycle = cycle + 1;
        if (i_in_valid && !i_rst) begin
            drive_q.push_back(cycle);
        end
        if (i_out_valid) begin
            check_output();
        end else if (cycle > 1 && i_out_error !== 1'b0) begin
            // Error flag belongs to a result strobe only
            $display("Error: o_error expected 0 got %h with no result strobe", i_out_error);
            value_errors++;
        end
        // End of stimulus, anything left over never came out
        if (i_end && !end_seen) begin
            end_seen = 1'b1;
            if (exp_tag_q.size() != 0) begin
                $display("Run ended with %0d expected results still missing",
                         exp_tag_q.size());
                order_errors += exp_tag_q.size();
            end
        end
    end

endmodule : bf16_reduce_checker

`default_nettype wire

// File: verification/tb_bf16_reduce.sv
// ----------------------------------------------------------------------
// BF16 reduction testbench
// ----------------------------------------------------------------------
`default_nettype none

`include "bf16_params.svh"

module tb_bf16_reduce;

    logic                                clk = 1'b0;
    logic                                rst;
    logic                                cmd_valid;
    logic [`BF16_OP_W-1:0]               cmd_op;
    logic [`BF16_TAG_W-1:0]              cmd_tag;
    logic [`BF16_NUM_LANES*`BF16_W-1:0]  cmd_values;
    logic                                out_valid;
    logic [`BF16_TAG_W-1:0]              out_tag;
    logic [`BF16_W-1:0]                  out_result;
    logic [`BF16_IDX_W-1:0]              out_index;
    logic                                out_error;

    int   value_errors;
    int   order_errors;
    int   checked;
    logic run_end = 1'b0;

    // Commands in file order
    logic [`BF16_OP_W-1:0]              op_q [$];
    logic [`BF16_TAG_W-1:0]             tag_q [$];
    logic [`BF16_NUM_LANES*`BF16_W-1:0] values_q [$];
    int                                 num_cmds = 0;
    bit                                 loaded = 1'b0;
    bit                                 file_failed = 1'b0;
    logic [31:0]                        lfsr_state = 32'hb6a2;

    always #10 clk = ~clk;

    bf16_reduce_top u_bf16_reduce_top (
        .i_clk         (clk),
        .i_rst         (rst),
        .i_valid       (cmd_valid),
        .i_op          (cmd_op),
        .i_tag         (cmd_tag),
        .i_values_flat (cmd_values),
        .o_valid       (out_valid),
        .o_tag         (out_tag),
        .o_result      (out_result),
        .o_index       (out_index),
        .o_error       (out_error)
    );

    bf16_reduce_checker u_bf16_reduce_checker (
        .i_clk          (clk),
        .i_rst          (rst),
        .i_in_valid     (cmd_valid),
        .i_out_valid    (out_valid),
        .i_out_tag      (out_tag),
        .i_out_result   (out_result),
        .i_out_index    (out_index),
        .i_out_error    (out_error),
        .i_end          (run_end),
        .o_value_errors (value_errors),
        .o_order_errors (order_errors),
        .o_checked      (checked)
    );

    // ------------------------------------------------------------------
    // Random gaps from a Galois LFSR
    // ------------------------------------------------------------------
    function automatic logic [31:0] lfsr_step(input logic [31:0] state);
        logic [31:0] next;
        next = state >> 1;
        if (state[0]) begin
            next = next ^ 32'h8020_0003;
        end
        return next;
    endfunction

    // Two bits, one LFSR step each
    task automatic random_gap(output int gap);
        gap = 0;
        for (int b = 0; b < 2; b++) begin
            gap = gap | (int'(lfsr_state[0]) << b);
            lfsr_state = lfsr_step(lfsr_state);
        end
    endtask

    // Closing line and verdict
    task automatic finish_run(input bit timed_out);
        int other_errors;
        other_errors = int'(timed_out) + int'(file_failed) + int'(num_cmds == 0);
        $display("Summary: %0d of %0d checked, %0d value errors, %0d sequence errors, %0d other",
                 checked, num_cmds, value_errors, order_errors, other_errors);
        if (value_errors + order_errors + other_errors == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    endtask

    // ------------------------------------------------------------------
    // Stimulus
    // ------------------------------------------------------------------
    initial begin
        int                                 fd;
        int                                 n;
        int                                 gap;
        string                              line;
        logic [`BF16_OP_W-1:0]              op;
        logic [`BF16_TAG_W-1:0]             tag;
        logic [`BF16_W-1:0]                 lane [`BF16_NUM_LANES];
        logic [`BF16_W-1:0]                 res;
        logic [`BF16_IDX_W-1:0]             idx;
        logic                               err;
        logic [`BF16_NUM_LANES*`BF16_W-1:0] flat;
        rst        = 1'b1;
        cmd_valid  = 1'b0;
        cmd_op     = '0;
        cmd_tag    = '0;
        cmd_values = '0;
        fd = $fopen("verification/bf16_reduce_input.txt", "r");
        if (fd == 0) begin
            $display("Could not open the command file");
            file_failed = 1'b1;
        end else begin
            while ($fgets(line, fd) > 0) begin
                if (line.len() < 2 || line.getc(0) == "#") begin
                    continue;
                end
                n = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h", op, tag,
                            lane[0], lane[1], lane[2], lane[3], lane[4], lane[5],
                            lane[6], lane[7], res, idx, err);
                // Only complete lines become commands
                if (n == 13) begin
                    // Lane 0 sits in the low bits
                    for (int k = 0; k < `BF16_NUM_LANES; k++) begin
                        flat[k*`BF16_W +: `BF16_W] = lane[k];
                    end
                    op_q.push_back(op);
                    tag_q.push_back(tag);
                    values_q.push_back(flat);
                end
            end
            $fclose(fd);
        end
        num_cmds = op_q.size();
        loaded   = 1'b1;

        repeat (3) @(posedge clk);
        rst <= 1'b0;

        foreach (op_q[i]) begin
            if (i > 0) begin
                random_gap(gap);
                repeat (gap) begin
                    @(posedge clk);
                    cmd_valid <= 1'b0;
                end
            end
            @(posedge clk);
            cmd_valid  <= 1'b1;
            cmd_op     <= op_q[i];
            cmd_tag    <= tag_q[i];
            cmd_values <= values_q[i];
        end
        @(posedge clk);
        cmd_valid <= 1'b0;

        // Drain bounded by the pipeline depth, then room for stray strobes
        for (int c = 0; c < 8 && checked != num_cmds; c++) begin
            @(posedge clk);
        end
        repeat (4) @(posedge clk);
        run_end <= 1'b1;
        repeat (2) @(posedge clk);
        finish_run(1'b0);
    end

    // Watchdog, four cycles per command plus reset and drain margin
    initial begin
        wait (loaded);
        #((num_cmds * 4 + 20) * 20);
        $display("Timeout: run did not finish within %0d cycles", num_cmds * 4 + 20);
        finish_run(1'b1);
    end

endmodule : tb_bf16_reduce

`default_nettype wire

// File: verification/bf16_reduce_input.txt
# op tag lane0 lane1 lane2 lane3 lane4 lane5 lane6 lane7 result index error
# all hex, op 0 maxabs, 1 scale exponent, 2 zero test, 3 illegal
0 0 3F80 C080 4000 BF80 3F00 0000 8000 4040 C080 1 0
0 1 3F80 3F00 BF80 4000 C000 3F80 4100 C120 C120 7 0
0 2 3F80 4040 0000 C040 4040 3F00 BF80 0000 4040 1 0
0 3 0000 0000 C0A0 40A0 3F80 C0A0 0000 0000 C0A0 2 0
0 4 7F80 C000 FF80 3F80 7FC0 0000 FF80 4000 7FC0 4 0
0 5 3F80 7F80 7FC0 0000 BF80 4000 FFC1 0000 FFC1 6 0
0 6 4000 FF80 7F80 C000 3F80 0000 0000 0000 FF80 1 0
1 7 3F80 C080 4000 BF80 3F00 0000 8000 4040 0081 1 0
1 8 3C00 BB80 0001 8000 3A00 0000 0000 3B00 0078 0 0
1 9 0000 7FC0 4000 0000 0000 0000 0000 0000 00FF 1 0
1 A 0001 807F 0040 0000 0000 0000 0000 0000 0000 1 0
2 B 0000 8000 0001 807F 0040 0000 8001 0000 0001 3 0
2 C 0000 0001 0000 0000 0000 0080 0000 807F 0000 5 0
2 D 0000 0000 0000 0000 0000 0000 0000 0000 0001 0 0
3 E 3F80 C080 4000 BF80 3F00 0000 8000 4040 0000 0 1
3 F 7FC0 0000 0000 0000 0000 0000 0000 4000 0000 0 1

// File: sources.f
+incdir+include
design/bf16_pkg.sv
design/bf16_comparator.sv
design/bf16_max_tree.sv
design/bf16_op_decode.sv
design/bf16_reduce_exec.sv
design/bf16_result_format.sv
design/bf16_reduce_top.sv
verification/bf16_reduce_checker.sv
verification/tb_bf16_reduce.sv

// File: Makefile
TOP = tb_bf16_reduce

.PHONY: all build lint clean

all: build
	./obj_dir/V$(TOP) | tee sim.log
	grep -q '^>>> PASS$$' sim.log

build:
	verilator --binary --timing -Wno-fatal -f sources.f --top-module $(TOP) -o V$(TOP)

lint:
	verilator --lint-only -Wall -f sources.f --top-module bf16_reduce_top

clean:
	rm -rf obj_dir sim.log
